//--- Bender.yml
package:
  name: butterfly

sources:
  - butterfly_pkg.sv
  - mod_addsub.sv
  - mod_mul.sv
  - butterfly.sv
  - butterfly_unit.sv
  - target: test
    files:
      - tb_butterfly.sv

//--- butterfly.sv
module butterfly (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 en,
    input  butterfly_pkg::bfly_mode_e            mode,
    input  logic [butterfly_pkg::coef_width-1:0] a,
    input  logic [butterfly_pkg::coef_width-1:0] b,
    input  logic [butterfly_pkg::coef_width-1:0] w,
    output logic [butterfly_pkg::coef_width-1:0] c,
    output logic [butterfly_pkg::coef_width-1:0] d
);
    import butterfly_pkg::*;

    // input register
    logic [coef_width-1:0] a_r;
    logic [coef_width-1:0] b_r;
    logic [coef_width-1:0] w_r;

    // delay lines
    logic [coef_width-1:0] w_dly;                       // intt twiddle, waits for diff
    logic [coef_width-1:0] a_dly   [bfly_latency-1];    // ntt tap and bypass
    logic [coef_width-1:0] b_dly   [bfly_latency-1];    // bypass only
    logic [coef_width-1:0] sum_dly [mul_latency];       // intt sum, waits for product

    // shared unit operands and results
    logic [coef_width-1:0] mul_x;
    logic [coef_width-1:0] mul_y;
    logic [coef_width-1:0] prod;
    logic [coef_width-1:0] add_x;
    logic [coef_width-1:0] add_y;
    logic [coef_width-1:0] sum;
    logic [coef_width-1:0] diff;

    ////////////////////////////////////////////////////////////
    // input register and a/b/w delays
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            a_r   <= '0;
            b_r   <= '0;
            w_r   <= '0;
            w_dly <= '0;
            for (int i = 0; i < bfly_latency-1; i++) begin
                a_dly[i] <= '0;
                b_dly[i] <= '0;
            end
        end else if (en) begin
            a_r      <= a;
            b_r      <= b;
            w_r      <= w;
            w_dly    <= w_r;
            a_dly[0] <= a_r;
            b_dly[0] <= b_r;
            for (int i = 1; i < bfly_latency-1; i++) begin
                a_dly[i] <= a_dly[i-1];
                b_dly[i] <= b_dly[i-1];
            end
        end
    end

    // intt sum waits out the multiplier
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < mul_latency; i++) begin
                sum_dly[i] <= '0;
            end
        end else if (en) begin
            sum_dly[0] <= sum;
            for (int i = 1; i < mul_latency; i++) begin
                sum_dly[i] <= sum_dly[i-1];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // operand routing
    ////////////////////////////////////////////////////////////

    // ntt: w*b then a +/- product, intt: a +/- b then diff*w
    always_comb begin
        if (mode == mode_intt) begin
            mul_x = w_dly;
            mul_y = diff;
            add_x = a_r;
            add_y = b_r;
        end else begin
            mul_x = w_r;
            mul_y = b_r;
            add_x = a_dly[mul_latency-1];   // a lined up with product
            add_y = prod;
        end
    end

    mod_mul u_mul (
        .clk   (clk),
        .reset (reset),
        .en    (en),
        .x     (mul_x),
        .y     (mul_y),
        .prod  (prod)
    );

    mod_addsub u_addsub (
        .clk   (clk),
        .reset (reset),
        .en    (en),
        .x     (add_x),
        .y     (add_y),
        .sum   (sum),
        .diff  (diff)
    );

    ////////////////////////////////////////////////////////////
    // output select
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (mode)
            mode_intt: begin
                c = sum_dly[mul_latency-1];
                d = prod;
            end
            mode_bypass: begin
                c = a_dly[bfly_latency-2];
                d = b_dly[bfly_latency-2];
            end
            default: begin      // ntt
                c = sum;
                d = diff;
            end
        endcase
    end

endmodule

//--- butterfly_pkg.sv
package butterfly_pkg;

    ////////////////////////////////////////////////////////////
    // kyber field
    ////////////////////////////////////////////////////////////

    localparam int coef_width = 12;     // coefficient and twiddle width
    localparam int kyber_q    = 3329;   // modulus
    localparam int prod_width = 24;     // raw 12x12 product

    // barrett constant, floor(2^24 / q)
    localparam int barrett_m     = 5039;
    localparam int barrett_shift = 24;

    ////////////////////////////////////////////////////////////
    // pipeline depths, in enabled cycles
    ////////////////////////////////////////////////////////////

    localparam int mul_latency    = 3;
    localparam int addsub_latency = 1;

    // input register + multiplier + adder/subtractor
    localparam int bfly_latency = 1 + mul_latency + addsub_latency;

    ////////////////////////////////////////////////////////////
    // butterfly mode
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        mode_ntt    = 2'd0,     // cooley-tukey
        mode_intt   = 2'd1,     // gentleman-sande
        mode_bypass = 2'd2      // c = a, d = b
    } bfly_mode_e;

endpackage

//--- butterfly_unit.sv
module butterfly_unit (
    input  logic                                 clk,
    input  logic                                 reset,
    input  butterfly_pkg::bfly_mode_e            mode,
    input  logic                                 in_valid,
    output logic                                 in_ready,
    input  logic [butterfly_pkg::coef_width-1:0] a,
    input  logic [butterfly_pkg::coef_width-1:0] b,
    input  logic [butterfly_pkg::coef_width-1:0] w,
    output logic                                 out_valid,
    input  logic                                 out_ready,
    output logic [butterfly_pkg::coef_width-1:0] c,
    output logic [butterfly_pkg::coef_width-1:0] d
);
    import butterfly_pkg::*;

    logic                              advance;     // whole pipe moves
    logic [bfly_latency-1:0]           valid_sr;    // one bit per stage
    logic [$clog2(bfly_latency+1)-1:0] in_flight;
    logic [coef_width-1:0]             a_in;
    logic [coef_width-1:0]             b_in;
    logic [coef_width-1:0]             w_in;

    ////////////////////////////////////////////////////////////
    // handshake and valid tracking
    ////////////////////////////////////////////////////////////

    assign advance   = !out_valid || out_ready;
    assign in_ready  = advance;
    assign out_valid = valid_sr[bfly_latency-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_sr <= '0;
        end else if (advance) begin
            valid_sr <= {valid_sr[bfly_latency-2:0], in_valid};
        end
    end

    always_comb begin
        in_flight = '0;
        for (int i = 0; i < bfly_latency; i++) begin
            in_flight = in_flight + valid_sr[i];
        end
    end

    // bubbles carry zeros so the datapath only sees residues
    assign a_in = in_valid ? a : '0;
    assign b_in = in_valid ? b : '0;
    assign w_in = in_valid ? w : '0;

    butterfly u_bfly (
        .clk   (clk),
        .reset (reset),
        .en    (advance),
        .mode  (mode),
        .a     (a_in),
        .b     (b_in),
        .w     (w_in),
        .c     (c),
        .d     (d)
    );

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // shared units would mix items of two modes
    a_mode_stable : assert property (
        @(posedge clk) disable iff (reset)
        (in_flight != 0) |-> $stable(mode)
    ) else $error("mode changed with %0d items in flight", in_flight);

    a_stall_hold : assert property (
        @(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> out_valid && $stable(c) && $stable(d)
    ) else $error("output changed under back-pressure");

endmodule

//--- mod_addsub.sv
module mod_addsub (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 en,
    input  logic [butterfly_pkg::coef_width-1:0] x,
    input  logic [butterfly_pkg::coef_width-1:0] y,
    output logic [butterfly_pkg::coef_width-1:0] sum,
    output logic [butterfly_pkg::coef_width-1:0] diff
);
    import butterfly_pkg::*;

    logic [coef_width:0] sum_raw;   // up to 2q-2
    logic [coef_width:0] diff_raw;  // msb is the borrow

    assign sum_raw  = x + y;
    assign diff_raw = {1'b0, x} - {1'b0, y};

    ////////////////////////////////////////////////////////////
    // one correction each way
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            sum  <= '0;
            diff <= '0;
        end else if (en) begin
            if (sum_raw >= kyber_q) begin
                sum <= coef_width'(sum_raw - kyber_q);
            end else begin
                sum <= sum_raw[coef_width-1:0];
            end
            // wrap back into range on borrow
            if (diff_raw[coef_width]) begin
                diff <= coef_width'(diff_raw + kyber_q);
            end else begin
                diff <= diff_raw[coef_width-1:0];
            end
        end
    end

    // single correction only holds for reduced operands
    a_operands_reduced : assert property (
        @(posedge clk) disable iff (reset)
        en |-> (x < kyber_q) && (y < kyber_q)
    ) else $error("mod_addsub operand not reduced, x=%0d y=%0d", x, y);

endmodule

//--- mod_mul.sv
module mod_mul (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 en,
    input  logic [butterfly_pkg::coef_width-1:0] x,
    input  logic [butterfly_pkg::coef_width-1:0] y,
    output logic [butterfly_pkg::coef_width-1:0] prod
);
    import butterfly_pkg::*;

    // stage 1
    logic [prod_width-1:0] mul_q;

    // stage 2
    logic [prod_width-1:0]            prod_q;
    logic [coef_width:0]              quot_q;   // estimate of prod / q
    logic [prod_width+coef_width:0]   scaled;   // mul_q * barrett_m

    // stage 3
    logic [prod_width-1:0] quot_times_q;
    logic [coef_width:0]   rem;                 // below 2q

    ////////////////////////////////////////////////////////////
    // stage 1, raw product
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            mul_q <= '0;
        end else if (en) begin
            mul_q <= x * y;
        end
    end

    ////////////////////////////////////////////////////////////
    // stage 2, barrett quotient
    ////////////////////////////////////////////////////////////

    assign scaled = mul_q * (prod_width+coef_width+1)'(barrett_m);

    always_ff @(posedge clk) begin
        if (reset) begin
            prod_q <= '0;
            quot_q <= '0;
        end else if (en) begin
            prod_q <= mul_q;
            quot_q <= scaled[prod_width+coef_width:barrett_shift];
        end
    end

    ////////////////////////////////////////////////////////////
    // stage 3, subtract and correct once
    ////////////////////////////////////////////////////////////

    assign quot_times_q = prod_width'(quot_q * kyber_q);
    assign rem          = (coef_width+1)'(prod_q - quot_times_q);

    always_ff @(posedge clk) begin
        if (reset) begin
            prod <= '0;
        end else if (en) begin
            if (rem >= kyber_q) begin
                prod <= coef_width'(rem - kyber_q);
            end else begin
                prod <= rem[coef_width-1:0];
            end
        end
    end

    // estimate is at most one short, so one correction is enough
    a_prod_reduced : assert property (
        @(posedge clk) disable iff (reset)
        prod < kyber_q
    ) else $error("mod_mul result %0d not below q", prod);

endmodule

//--- tb_butterfly.sv
module tb_butterfly;
    timeunit 1ns;
    timeprecision 1ps;

    import butterfly_pkg::*;

    localparam int half_period   = 20;
    localparam int seed          = 20361;
    localparam int num_groups    = 4;
    localparam int per_group     = 16;
    localparam int num_vectors   = num_groups * per_group;
    localparam int num_edge_rows = 5;
    localparam int timeout_ns    = (num_vectors + num_groups) * bfly_latency * 4 * 2 * half_period;

    logic                  clk;
    logic                  reset;
    bfly_mode_e            mode;
    logic                  in_valid;
    logic                  in_ready;
    logic [coef_width-1:0] a;
    logic [coef_width-1:0] b;
    logic [coef_width-1:0] w;
    logic                  out_valid;
    logic                  out_ready;
    logic [coef_width-1:0] c;
    logic [coef_width-1:0] d;

    // vector table, stimulus and expected columns
    bfly_mode_e tbl_mode  [num_vectors];
    int         tbl_a     [num_vectors];
    int         tbl_b     [num_vectors];
    int         tbl_w     [num_vectors];
    int         tbl_exp_c [num_vectors];
    int         tbl_exp_d [num_vectors];

    bfly_mode_e group_mode [num_groups] = '{mode_ntt, mode_intt, mode_bypass, mode_ntt};
    string      group_name [num_groups] = '{"ntt", "intt", "bypass", "back-pressure"};

    int          exp_c_q  [$];
    int          exp_d_q  [$];
    int          accept_q [$];     // cycle of acceptance, for latency
    logic [15:0] lfsr_state;
    int          cycle;
    int          checks;
    int          errors;

    butterfly_unit butterfly_unit_i (
        .clk       (clk),
        .reset     (reset),
        .mode      (mode),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .a         (a),
        .b         (b),
        .w         (w),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .c         (c),
        .d         (d)
    );

    initial clk = 1'b0;
    always #(half_period) clk = ~clk;

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic int random_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | lfsr_state[0];
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 16'hb400;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return value;
    endfunction

    // integer reference of the three modes
    task automatic model_butterfly(input bfly_mode_e m, input int av, input int bv,
                                   input int wv, output int cv, output int dv);
        int t;
        case (m)
            mode_ntt: begin
                t  = (wv * bv) % kyber_q;
                cv = (av + t) % kyber_q;
                dv = (av - t + kyber_q) % kyber_q;
            end
            mode_intt: begin
                cv = (av + bv) % kyber_q;
                dv = (((av - bv + kyber_q) % kyber_q) * wv) % kyber_q;
            end
            default: begin
                cv = av;
                dv = bv;
            end
        endcase
    endtask

    task automatic check_output(input bit bp);
        int want_c;
        int want_d;
        int accepted;
        assert (exp_c_q.size() > 0) else begin
            $display("output transfer at %0t ns with no item pending", $time);
            errors++;
        end
        if (exp_c_q.size() == 0) begin
            return;
        end
        want_c   = exp_c_q.pop_front();
        want_d   = exp_d_q.pop_front();
        accepted = accept_q.pop_front();
        checks++;
        assert (c == want_c) else begin
            $display("Fail %0t ns: c is %0d, expected %0d", $time, c, want_c);
            errors++;
        end
        assert (d == want_d) else begin
            $display("Fail %0t ns: d is %0d, expected %0d", $time, d, want_d);
            errors++;
        end
        if (!bp) begin
            assert (cycle - accepted == bfly_latency) else begin
                $display("result came %0d cycles after acceptance instead of %0d, at %0t ns",
                         cycle - accepted, bfly_latency, $time);
                errors++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // one group of rows, then drain
    ////////////////////////////////////////////////////////////

    task automatic run_group(input int g);
        int                    first;
        int                    next;
        bit                    bp;
        bit                    was_stalled;
        logic [coef_width-1:0] held_c;
        logic [coef_width-1:0] held_d;
        int                    errors_before;
        first         = g * per_group;
        next          = first;
        bp            = (g == num_groups - 1);
        was_stalled   = 1'b0;
        errors_before = errors;
        @(negedge clk);
        mode     = group_mode[g];   // pipe is empty here
        in_valid = 1'b0;
        while (next < first + per_group || exp_c_q.size() > 0) begin
            @(negedge clk);
            cycle++;
            out_ready = bp ? (random_bits(2) != 0) : 1'b1;   // low about 1 in 4
            if (next < first + per_group) begin
                in_valid = 1'b1;
                a        = tbl_a[next];
                b        = tbl_b[next];
                w        = tbl_w[next];
            end else begin
                in_valid = 1'b0;
                a        = '0;
                b        = '0;
                w        = '0;
            end
            #1;
            if (was_stalled) begin
                assert (out_valid && c == held_c && d == held_d) else begin
                    $display("output changed while stalled at %0t ns", $time);
                    errors++;
                end
            end
            was_stalled = out_valid && !out_ready;
            held_c      = c;
            held_d      = d;
            if (out_valid && out_ready) begin
                check_output(bp);
            end
            // a stalled output freezes the whole pipe
            if (out_valid && !out_ready) begin
                assert (!in_ready) else begin
                    $display("input taken at %0t ns while the output was stalled", $time);
                    errors++;
                end
            end else begin
                assert (in_ready) else begin
                    $display("input refused at %0t ns with no stall", $time);
                    errors++;
                end
            end
            if (in_valid && in_ready) begin
                exp_c_q.push_back(tbl_exp_c[next]);
                exp_d_q.push_back(tbl_exp_d[next]);
                accept_q.push_back(cycle);
                next++;
            end
        end
        // idle before the next mode, nothing more may come out
        repeat (2) begin
            @(negedge clk);
            assert (!out_valid) else begin
                $display("extra output at %0t ns after all items were checked", $time);
                errors++;
            end
        end
        $display("test %s: %0d items, %0d errors", group_name[g], per_group,
                 errors - errors_before);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        reset      = 1'b1;
        mode       = mode_ntt;
        in_valid   = 1'b0;
        a          = '0;
        b          = '0;
        w          = '0;
        out_ready  = 1'b0;
        lfsr_state = 16'(seed);
        cycle      = 0;
        checks     = 0;
        errors     = 0;

        for (int i = 0; i < num_vectors; i++) begin
            tbl_mode[i] = group_mode[i / per_group];
            tbl_a[i]    = random_bits(coef_width) % kyber_q;
            tbl_b[i]    = random_bits(coef_width) % kyber_q;
            tbl_w[i]    = random_bits(coef_width) % kyber_q;
        end
        // edge rows at the head of the first three groups
        for (int g = 0; g < num_groups - 1; g++) begin
            tbl_a[g*per_group]   = 0;
            tbl_b[g*per_group]   = 0;
            tbl_w[g*per_group]   = 0;
            tbl_a[g*per_group+1] = 1;
            tbl_b[g*per_group+1] = 1;
            tbl_w[g*per_group+1] = 1;
            tbl_a[g*per_group+2] = kyber_q - 1;
            tbl_b[g*per_group+2] = kyber_q - 1;
            tbl_w[g*per_group+2] = kyber_q - 1;
            tbl_a[g*per_group+3] = kyber_q - 1;
            tbl_b[g*per_group+3] = 1;
            tbl_w[g*per_group+3] = 0;               // w = 0
            tbl_a[g*per_group+4] = 5;
            tbl_b[g*per_group+4] = kyber_q - 1;
            tbl_w[g*per_group+4] = 1;               // w = 1
        end
        for (int i = 0; i < num_vectors; i++) begin
            model_butterfly(tbl_mode[i], tbl_a[i], tbl_b[i], tbl_w[i],
                            tbl_exp_c[i], tbl_exp_d[i]);
        end

        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        @(negedge clk);
        #1;
        checks++;
        assert (!out_valid && in_ready) else begin
            $display("Fail %0t ns: after reset out_valid=%0b in_ready=%0b",
                     $time, out_valid, in_ready);
            errors++;
        end
        $display("test reset: %0d errors", errors);

        for (int g = 0; g < num_groups; g++) begin
            run_group(g);
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(timeout_ns);
        $display("timeout: outputs stopped arriving");
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- verilog.f
butterfly_pkg.sv
mod_addsub.sv
mod_mul.sv
butterfly.sv
butterfly_unit.sv
tb_butterfly.sv
